// File: common/dataPkg.sv
package dataPkg;

	parameter int WordBits = 32;

	// one bus word
	typedef logic [WordBits-1:0] wordT;

	// ALU result, high half to Zhi and low half to Zlo
	typedef logic [2*WordBits-1:0] dwordT;

	// iterations per multiply or divide, one per result bit
	parameter int MulDivCycles = WordBits;

	// x / 0 gives all ones in the quotient and leaves the dividend as remainder
	parameter wordT DivZeroQuot = '1;

endpackage

// File: common/ctrlPkg.sv
package ctrlPkg;

	// ALU function select driven by the sequencer
	typedef enum logic [3:0] {
		OpAdd,
		OpSub,
		OpAnd,
		OpOr,
		OpShr,
		OpShra,
		OpShl,
		OpRor,
		OpRol,
		OpNeg,
		OpNot,
		OpMul,  // iterative, behind the handshake
		OpDiv   // iterative, behind the handshake
	} aluOpT;

	// positions in the bus source vector, lowest wins
	typedef enum int unsigned {
		SrcPc,
		SrcIr,
		SrcZhi,
		SrcZlo,
		SrcMdr,
		SrcReg0  // R0, the other general registers follow
	} busSrcT;

endpackage

// File: common/mulDivIf.sv
`timescale 1ns/1ps

interface mulDivIf;
	import dataPkg::*;
	import ctrlPkg::*;

	logic req;
	aluOpT op;
	wordT a;        // Y side
	wordT b;        // bus side
	logic ack;
	dwordT result;  // valid while ack is high

	modport requester (output req, op, a, b, input ack, result);
	modport responder (input req, op, a, b, output ack, result);

endinterface

// File: src/RegisterFile.sv
`timescale 1ns/1ps

module RegisterFile #(
	parameter int NumRegs = 16
) (
	input logic Clock,
	input logic rst,
	input dataPkg::wordT busIn,
	input logic pcIn,
	input logic irIn,
	input logic yIn,
	input logic [NumRegs-1:0] regIn,
	output dataPkg::wordT regs [NumRegs],
	output dataPkg::wordT pc,
	output dataPkg::wordT ir,
	output dataPkg::wordT y
);

	// general registers
	always_ff @(posedge Clock) begin
		for (int i = 0; i < NumRegs; i++) begin
			if (rst) begin
				regs[i] <= '0;
			end else if (regIn[i]) begin
				regs[i] <= busIn;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			pc <= '0;
		end else if (pcIn) begin
			pc <= busIn;
		end
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			ir <= '0;
		end else if (irIn) begin
			ir <= busIn;
		end
	end

	// operand latch in front of the ALU
	always_ff @(posedge Clock) begin
		if (rst) begin
			y <= '0;
		end else if (yIn) begin
			y <= busIn;
		end
	end

endmodule

// File: src/MemoryPort.sv
`timescale 1ns/1ps

module MemoryPort (
	input logic Clock,
	input logic rst,
	input dataPkg::wordT busIn,
	input dataPkg::wordT mdataIn,
	input logic marIn,
	input logic mdrIn,
	input logic read,
	output dataPkg::wordT mar,
	output dataPkg::wordT mdr
);

	always_ff @(posedge Clock) begin
		if (rst) begin
			mar <= '0;
		end else if (marIn) begin
			mar <= busIn;  // straight out to memAddr
		end
	end

	// read picks memory data, otherwise the bus is written back
	always_ff @(posedge Clock) begin
		if (rst) begin
			mdr <= '0;
		end else if (mdrIn) begin
			if (read) begin
				mdr <= mdataIn;
			end else begin
				mdr <= busIn;
			end
		end
	end

endmodule

// File: src/BusMux.sv
`timescale 1ns/1ps

module BusMux #(
	parameter int NumRegs = 16
) (
	input dataPkg::wordT regs [NumRegs],
	input dataPkg::wordT pc,
	input dataPkg::wordT ir,
	input dataPkg::wordT zHi,
	input dataPkg::wordT zLo,
	input dataPkg::wordT mdr,
	input logic pcOut,
	input logic irOut,
	input logic zHiOut,
	input logic zLoOut,
	input logic mdrOut,
	input logic [NumRegs-1:0] regOut,
	output dataPkg::wordT busOut
);
	import dataPkg::*;
	import ctrlPkg::*;

	localparam int NumSrc = int'(SrcReg0) + NumRegs;

	logic [NumSrc-1:0] sel;
	wordT src [NumSrc];

	always_comb begin
		sel[SrcPc] = pcOut;
		sel[SrcIr] = irOut;
		sel[SrcZhi] = zHiOut;
		sel[SrcZlo] = zLoOut;
		sel[SrcMdr] = mdrOut;
		src[SrcPc] = pc;
		src[SrcIr] = ir;
		src[SrcZhi] = zHi;
		src[SrcZlo] = zLo;
		src[SrcMdr] = mdr;
		for (int i = 0; i < NumRegs; i++) begin
			sel[int'(SrcReg0) + i] = regOut[i];
			src[int'(SrcReg0) + i] = regs[i];
		end
	end

	// scan from the top so the lowest set index ends up on the bus
	always_comb begin
		busOut = '0;
		for (int i = NumSrc - 1; i >= 0; i--) begin
			if (sel[i]) begin
				busOut = src[i];
			end
		end
	end

endmodule

// File: alu/AluStage.sv
`timescale 1ns/1ps

module AluStage (
	input logic Clock,
	input logic rst,
	input dataPkg::wordT y,
	input dataPkg::wordT busIn,
	input ctrlPkg::aluOpT aluOp,
	input logic incPc,
	input logic zIn,
	input logic mdReq,
	output dataPkg::wordT zHi,
	output dataPkg::wordT zLo,
	output logic mdAck,
	mulDivIf.requester md
);
	import dataPkg::*;
	import ctrlPkg::*;

	wordT a;
	aluOpT op;
	logic [4:0] sh;
	logic isMulDiv;
	wordT lo;
	dwordT rot;
	dwordT aluRes;

	assign a = incPc ? wordT'(1) : y;  // PC + 1 through the adder
	assign op = incPc ? OpAdd : aluOp;
	assign sh = busIn[4:0];
	assign isMulDiv = (op == OpMul) || (op == OpDiv);

	assign md.req = mdReq && isMulDiv;
	assign md.op = op;
	assign md.a = a;
	assign md.b = busIn;
	assign mdAck = md.ack;

	always_comb begin
		lo = '0;
		rot = '0;
		case (op)
			OpAdd: lo = a + busIn;
			OpSub: lo = a - busIn;
			OpAnd: lo = a & busIn;
			OpOr: lo = a | busIn;
			OpShr: lo = a >> sh;
			OpShra: lo = $signed(a) >>> sh;
			OpShl: lo = a << sh;
			OpRor: begin
				rot = {a, a} >> sh;
				lo = rot[31:0];
			end
			OpRol: begin
				rot = {a, a} << sh;
				lo = rot[63:32];
			end
			OpNeg: lo = -busIn;
			OpNot: lo = ~busIn;
			default: lo = '0;  // mul/div come from the unit
		endcase
	end

	assign aluRes = isMulDiv ? md.result : {wordT'(0), lo};

	always_ff @(posedge Clock) begin
		if (rst) begin
			zHi <= '0;
			zLo <= '0;
		end else if (zIn) begin
			{zHi, zLo} <= aluRes;
		end
	end

endmodule

// File: alu/MulDivUnit.sv
`timescale 1ns/1ps

module MulDivUnit (
	input logic Clock,
	input logic rst,
	mulDivIf.responder md
);
	import dataPkg::*;
	import ctrlPkg::*;

	typedef enum logic [1:0] {Idle, Busy, Done, Release} stateT;

	stateT state;
	logic [$clog2(MulDivCycles)-1:0] cnt;
	logic isDiv;
	wordT opnd;  // multiplicand or divisor
	wordT hi;    // product high half / partial remainder
	wordT lo;    // multiplier shifting out / quotient shifting in
	logic [32:0] sum;
	logic [32:0] shifted;
	logic [33:0] diff;

	always_comb begin
		sum = {1'b0, hi} + (lo[0] ? {1'b0, opnd} : 33'd0);
		shifted = {hi, lo[31]};
		diff = {1'b0, shifted} - {2'b00, opnd};
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			state <= Idle;
			cnt <= '0;
		end else begin
			case (state)
				Idle: begin
					if (md.req) begin
						state <= Busy;
						cnt <= '0;
					end
				end
				Busy: begin
					cnt <= cnt + 1'b1;
					if (cnt == ($bits(cnt))'(MulDivCycles - 1)) begin
						state <= Done;
					end
				end
				Done: state <= Release;
				Release: begin
					if (!md.req) begin
						state <= Idle;
					end
				end
				default: state <= Idle;
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		case (state)
			Idle: begin
				if (md.req) begin
					isDiv <= (md.op == OpDiv);
					opnd <= (md.op == OpDiv) ? md.b : md.a;
					lo <= (md.op == OpDiv) ? md.a : md.b;
					hi <= '0;
				end
			end
			Busy: begin
				if (!isDiv) begin
					hi <= sum[32:1];
					lo <= {sum[0], lo[31:1]};
				end else if (!diff[33]) begin  // fits, keep the difference
					hi <= diff[31:0];
					lo <= {lo[30:0], 1'b1};
				end else begin
					hi <= shifted[31:0];
					lo <= {lo[30:0], 1'b0};
				end
			end
			Done: begin
				if (isDiv && opnd == '0) begin
					lo <= DivZeroQuot;
				end
			end
			default: ;
		endcase
	end

	assign md.ack = (state == Release);
	assign md.result = {hi, lo};

endmodule

// File: src/DataPath.sv
`timescale 1ns/1ps

module DataPath #(
	parameter int NumRegs = 16
) (
	input logic Clock,
	input logic rst,
	input logic pcIn,
	input logic irIn,
	input logic yIn,
	input logic marIn,
	input logic mdrIn,
	input logic zIn,
	input logic [NumRegs-1:0] regIn,
	input logic pcOut,
	input logic irOut,
	input logic zHiOut,
	input logic zLoOut,
	input logic mdrOut,
	input logic [NumRegs-1:0] regOut,
	input logic read,
	input logic incPc,
	input ctrlPkg::aluOpT aluOp,
	input dataPkg::wordT mdataIn,
	input logic mdReq,
	output logic mdAck,
	output dataPkg::wordT busOut,
	output dataPkg::wordT memAddr
);
	import dataPkg::*;

	wordT regs [NumRegs];
	wordT pc, ir, y;
	wordT mdr;
	wordT zHi, zLo;

	mulDivIf md0 ();

	RegisterFile #(.NumRegs(NumRegs)) regFile0 (
		.Clock(Clock), .rst(rst), .busIn(busOut),
		.pcIn(pcIn), .irIn(irIn), .yIn(yIn), .regIn(regIn),
		.regs(regs), .pc(pc), .ir(ir), .y(y)
	);

	MemoryPort memPort0 (
		.Clock(Clock), .rst(rst), .busIn(busOut), .mdataIn(mdataIn),
		.marIn(marIn), .mdrIn(mdrIn), .read(read),
		.mar(memAddr), .mdr(mdr)
	);

	BusMux #(.NumRegs(NumRegs)) busMux0 (
		.regs(regs), .pc(pc), .ir(ir), .zHi(zHi), .zLo(zLo), .mdr(mdr),
		.pcOut(pcOut), .irOut(irOut), .zHiOut(zHiOut), .zLoOut(zLoOut),
		.mdrOut(mdrOut), .regOut(regOut), .busOut(busOut)
	);

	AluStage alu0 (
		.Clock(Clock), .rst(rst), .y(y), .busIn(busOut), .aluOp(aluOp),
		.incPc(incPc), .zIn(zIn), .mdReq(mdReq),
		.zHi(zHi), .zLo(zLo), .mdAck(mdAck), .md(md0.requester)
	);

	MulDivUnit mulDiv0 (
		.Clock(Clock), .rst(rst), .md(md0.responder)
	);

endmodule

// File: testbench/tbDataPath.sv
`timescale 1ns/1ps

module tbDataPath;
	import dataPkg::*;
	import ctrlPkg::*;

	localparam int TbRegs = 16;
	localparam int DstPc = 0;
	localparam int DstIr = 1;
	localparam int DstY = 2;
	localparam int DstMar = 3;
	localparam int DstReg0 = 4;
	localparam int NumMemTests = 8;
	localparam int NumAluRounds = 3;
	localparam int NumMulDiv = 11;
	localparam int NumOps = 2 + NumMemTests + NumAluRounds * 11 + 3 + NumMulDiv + 1;
	localparam int WatchdogCycles = NumOps * (MulDivCycles + 10) + 100;
	localparam aluOpT SingleOps [11] = '{OpAdd, OpSub, OpAnd, OpOr, OpShr, OpShra, OpShl,
		OpRor, OpRol, OpNeg, OpNot};

	typedef logic [TbRegs-1:0] regVecT;

	logic Clock, rst;
	logic pcIn, irIn, yIn, marIn, mdrIn, zIn;
	logic pcOut, irOut, zHiOut, zLoOut, mdrOut;
	logic read, incPc, mdReq, mdAck;
	regVecT regIn, regOut;
	aluOpT aluOp;
	wordT mdataIn, busOut, memAddr;
	wordT seed = 32'h4a7c_c713;
	wordT a, b;
	int errors = 0;
	int checks = 0;
	int r, r2;

	DataPath #(.NumRegs(TbRegs)) dut0 (
		.Clock(Clock), .rst(rst), .pcIn(pcIn), .irIn(irIn), .yIn(yIn), .marIn(marIn),
		.mdrIn(mdrIn), .zIn(zIn), .regIn(regIn), .pcOut(pcOut), .irOut(irOut),
		.zHiOut(zHiOut), .zLoOut(zLoOut), .mdrOut(mdrOut), .regOut(regOut), .read(read),
		.incPc(incPc), .aluOp(aluOp), .mdataIn(mdataIn), .mdReq(mdReq), .mdAck(mdAck),
		.busOut(busOut), .memAddr(memAddr)
	);

	initial begin
		Clock = 1'b0;
		forever #2 Clock = ~Clock;
	end

	initial begin
		repeat (WatchdogCycles) @(posedge Clock);
		$display("Watchdog expired after %0d cycles, %0d checks, %0d errors",
			WatchdogCycles, checks, errors);
		$display("Errors found");
		$finish;
	end

	function automatic wordT nextRand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// reference for the one-cycle ops with a from Y and b from the bus
	function automatic wordT aluModel(input aluOpT op, input wordT x, input wordT y);
		int s;
		wordT v;
		s = int'(y[4:0]);
		v = x;
		case (op)
			OpAdd: v = x + y;
			OpSub: v = x + ~y + 32'd1;
			OpAnd: v = x & y;
			OpOr: v = x | y;
			OpShr: v = x >> y[4:0];
			OpShl: v = x << y[4:0];
			OpShra: for (int i = 0; i < s; i++) v = {v[31], v[31:1]};
			OpRor: for (int i = 0; i < s; i++) v = {v[0], v[31:1]};
			OpRol: for (int i = 0; i < s; i++) v = {v[30:0], v[31]};
			OpNeg: v = ~y + 32'd1;
			OpNot: v = ~y;
			default: v = '0;
		endcase
		return v;
	endfunction

	task automatic beginStep();
		@(posedge Clock);
		{pcIn, irIn, yIn, marIn, mdrIn, zIn, pcOut, irOut, zHiOut, zLoOut, mdrOut} <= '0;
		{read, incPc} <= '0;
		regIn <= '0;
		regOut <= '0;
	endtask

	task automatic driveSrc(input int src);
		case (src)
			int'(SrcPc): pcOut <= 1'b1;
			int'(SrcIr): irOut <= 1'b1;
			int'(SrcZhi): zHiOut <= 1'b1;
			int'(SrcZlo): zLoOut <= 1'b1;
			int'(SrcMdr): mdrOut <= 1'b1;
			default: regOut <= regVecT'(1) << (src - int'(SrcReg0));
		endcase
	endtask

	task automatic driveDst(input int dst);
		case (dst)
			DstPc: pcIn <= 1'b1;
			DstIr: irIn <= 1'b1;
			DstY: yIn <= 1'b1;
			DstMar: marIn <= 1'b1;
			default: regIn <= regVecT'(1) << (dst - DstReg0);
		endcase
	endtask

	task automatic checkBus(input string what, input wordT want);
		@(negedge Clock);
		checks++;
		assert (busOut === want) else begin
			errors++;
			$display("FAILED at %0t: busOut (%s) expected %h, got %h", $time, what, want, busOut);
		end
	endtask

	task automatic checkAddr(input wordT want);
		@(negedge Clock);
		checks++;
		assert (memAddr === want) else begin
			errors++;
			$display("FAILED at %0t: memAddr expected %h, got %h", $time, want, memAddr);
		end
	endtask

	task automatic checkAck(input string what, input logic want);
		@(negedge Clock);
		checks++;
		assert (mdAck === want) else begin
			errors++;
			$display("FAILED at %0t: mdAck (%s) expected %b, got %b", $time, what, want, mdAck);
		end
	endtask

	task automatic putMdr(input wordT data);
		beginStep();
		read <= 1'b1;
		mdrIn <= 1'b1;
		mdataIn <= data;
	endtask

	task automatic move(input int src, input int dst, input string what, input wordT want);
		beginStep();
		driveSrc(src);
		driveDst(dst);
		checkBus(what, want);
	endtask

	task automatic readBack(input int src, input string what, input wordT want);
		beginStep();
		driveSrc(src);
		checkBus(what, want);
	endtask

	task automatic loadReg(input int dst, input wordT data);
		putMdr(data);
		move(int'(SrcMdr), dst, "MDR", data);
	endtask

	task automatic aluTest(input aluOpT op, input wordT x, input wordT y);
		loadReg(DstY, x);
		putMdr(y);
		beginStep();
		mdrOut <= 1'b1;
		aluOp <= op;
		zIn <= 1'b1;
		readBack(int'(SrcZlo), op.name(), aluModel(op, x, y));
		readBack(int'(SrcZhi), "Zhi after one-cycle op", '0);
	endtask

	task automatic mulDivTest(input aluOpT op, input wordT x, input wordT y);
		wordT wantHi;
		wordT wantLo;
		int latency;
		if (op == OpMul) begin
			{wantHi, wantLo} = dwordT'(x) * dwordT'(y);
		end else if (y == '0) begin
			wantLo = '1;
			wantHi = x;
		end else begin
			wantLo = x / y;
			wantHi = x % y;
		end
		loadReg(DstY, x);
		putMdr(y);
		beginStep();
		mdrOut <= 1'b1;
		aluOp <= op;
		mdReq <= 1'b1;
		@(posedge Clock);  // unit sees the request here
		latency = 0;
		@(negedge Clock);
		while (!mdAck && latency <= MulDivCycles + 10) begin
			@(posedge Clock);
			latency++;
			@(negedge Clock);
		end
		if (!mdAck) begin
			errors++;
			$display("%s of %h and %h: mdAck never came back", op.name(), x, y);
			@(posedge Clock);
			mdReq <= 1'b0;
		end else begin
			checks++;
			assert (latency == MulDivCycles + 1) else begin
				errors++;
				$display("FAILED at %0t: mdAck latency expected %0d, got %0d",
					$time, MulDivCycles + 1, latency);
			end
			@(posedge Clock);
			zIn <= 1'b1;
			@(posedge Clock);
			zIn <= 1'b0;
			mdReq <= 1'b0;
			checkAck("held while mdReq drops", 1'b1);
			checkAck("one cycle after mdReq drops", 1'b0);
			readBack(int'(SrcZlo), op.name(), wantLo);
			readBack(int'(SrcZhi), op.name(), wantHi);
		end
	endtask

	initial begin
		rst = 1'b1;
		{pcIn, irIn, yIn, marIn, mdrIn, zIn, pcOut, irOut, zHiOut, zLoOut, mdrOut} = '0;
		{read, incPc, mdReq} = '0;
		regIn = '0;
		regOut = '0;
		aluOp = OpAdd;
		mdataIn = '0;
		repeat (8) @(posedge Clock);
		rst <= 1'b0;

		for (int i = 0; i < int'(SrcReg0) + TbRegs; i++) begin
			readBack(i, "after reset", '0);
		end
		checkAddr('0);
		checkAck("after reset", 1'b0);
		beginStep();
		driveSrc(int'(SrcReg0));
		aluOp <= OpOr;  // Y | 0 shows Y
		zIn <= 1'b1;
		readBack(int'(SrcZlo), "Y after reset", '0);

		for (int n = 0; n < NumMemTests; n++) begin
			a = nextRand();
			b = nextRand();
			r = int'(nextRand() % 32'(TbRegs));
			r2 = (r + 1 + int'(nextRand() % 32'(TbRegs - 1))) % TbRegs;
			putMdr(a);
			move(int'(SrcMdr), DstMar, "MDR to MAR", a);
			checkAddr(a);
			loadReg(DstReg0 + r, b);
			move(int'(SrcReg0) + r, DstReg0 + r2, "register copy", b);
			move(int'(SrcReg0) + r2, DstIr, "copied register", b);
			readBack(int'(SrcIr), "IR", b);
		end

		for (int n = 0; n < NumAluRounds; n++) begin
			foreach (SingleOps[k]) begin
				aluTest(SingleOps[k], nextRand(), nextRand());
			end
		end

		for (int k = 0; k < 3; k++) begin
			a = (k == 0) ? 32'h0 : ((k == 1) ? nextRand() : 32'hffff_ffff);
			loadReg(DstPc, a);
			beginStep();
			pcOut <= 1'b1;
			incPc <= 1'b1;
			zIn <= 1'b1;
			move(int'(SrcZlo), DstPc, "PC+1 via Zlo", a + 32'd1);
			readBack(int'(SrcPc), "PC after increment", a + 32'd1);
		end

		for (int n = 0; n < 4; n++) begin
			mulDivTest(OpMul, nextRand(), nextRand());
			mulDivTest(OpDiv, nextRand(), nextRand() >> 16);
		end
		mulDivTest(OpDiv, nextRand(), '0);
		mulDivTest(OpMul, 32'hffff_ffff, 32'hffff_ffff);
		mulDivTest(OpDiv, 32'h0000_0123, 32'h8000_0001);  // divisor above dividend
		aluTest(OpAnd, nextRand(), nextRand());  // Zhi still holds a remainder here

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: list.f
common/dataPkg.sv
common/ctrlPkg.sv
common/mulDivIf.sv
src/RegisterFile.sv
src/MemoryPort.sv
src/BusMux.sv
alu/AluStage.sv
alu/MulDivUnit.sv
src/DataPath.sv
testbench/tbDataPath.sv

// File: Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tbDataPath
FILELIST ?= list.f
OBJDIR   ?= obj_dir
PASS_MSG := No errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
